// ==== project.f ====
rtl/vm16_pkg.sv
rtl/vm16_alu.sv
rtl/vm16_decoder.sv
rtl/vm16_regfile.sv
rtl/vm16_bram.sv
rtl/vm16_control.sv
rtl/vm16_core.sv
tb/vm16_tb.sv

// ==== rtl/vm16_alu.sv ====
// vm16 arithmetic and bit unit
`timescale 1ns/1ns

module vm16_alu (
    input  vm16_pkg::alu_op_e             op,
    input  logic [vm16_pkg::data_w-1:0]   a,
    input  logic [vm16_pkg::data_w-1:0]   b,
    output logic [vm16_pkg::data_w-1:0]   c
);

    always_comb begin
        case (op)
            // mov, movi and memory addresses
            vm16_pkg::alu_pass_b: c = b;
            vm16_pkg::alu_or:     c = a | b;
            vm16_pkg::alu_xor:    c = a ^ b;
            vm16_pkg::alu_and:    c = a & b;
            vm16_pkg::alu_not:    c = ~b;
            vm16_pkg::alu_lshft:  c = a << b;
            vm16_pkg::alu_rshft:  c = a >> b;
            vm16_pkg::alu_uadd:   c = a + b;
            vm16_pkg::alu_usub:   c = a - b;
            // two's complement, so the bits match the unsigned forms
            vm16_pkg::alu_sadd:   c = $signed(a) + $signed(b);
            vm16_pkg::alu_ssub:   c = $signed(a) - $signed(b);
            default:              c = '0;
        endcase
    end

endmodule

// ==== rtl/vm16_bram.sv ====
// vm16 single port block memory
`timescale 1ns/1ns

module vm16_bram (
    input  logic                                clk,
    input  logic [vm16_pkg::scratch_addr_w-1:0] addr,
    input  logic [vm16_pkg::data_w-1:0]         wdata,
    input  logic                                we,
    output logic [vm16_pkg::data_w-1:0]         rdata
);

    logic [vm16_pkg::data_w-1:0] mem [vm16_pkg::scratch_depth];

    initial begin
        for (int i = 0; i < vm16_pkg::scratch_depth; i++) begin
            mem[i] = '0;
        end
    end

    // output holds its last value while a write is in progress
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

// ==== rtl/vm16_control.sv ====
// vm16 control FSM and datapath registers
`timescale 1ns/1ns

module vm16_control (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 run,
    output logic [vm16_pkg::instr_addr_w-1:0]    imem_addr,
    input  logic [vm16_pkg::data_w-1:0]          imem_rdata,
    input  vm16_pkg::ctrl_t                      ctrl,
    output vm16_pkg::instr_t                     instr,
    output logic [vm16_pkg::reg_sel_w-1:0]       rsel,
    input  logic [vm16_pkg::data_w-1:0]          rdata,
    output vm16_pkg::alu_op_e                    alu_op,
    output logic [vm16_pkg::data_w-1:0]          alu_a,
    output logic [vm16_pkg::data_w-1:0]          alu_b,
    input  logic [vm16_pkg::data_w-1:0]          alu_c,
    output logic [vm16_pkg::scratch_addr_w-1:0]  smem_addr,
    output logic [vm16_pkg::data_w-1:0]          smem_wdata,
    output logic                                 smem_we,
    input  logic [vm16_pkg::data_w-1:0]          smem_rdata,
    output vm16_pkg::wb_t                        wb,
    output logic                                 halted
);

    vm16_pkg::state_e                    state;
    logic [vm16_pkg::instr_addr_w-1:0]   pc;
    logic [vm16_pkg::scratch_addr_w-1:0] mem_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= vm16_pkg::st_idle;
            pc     <= '0;
            halted <= 1'b0;
        end else begin
            case (state)
                // once halted the core stays here until reset
                vm16_pkg::st_idle: begin
                    if (run && !halted) begin
                        state <= vm16_pkg::st_fetch;
                    end
                end
                vm16_pkg::st_fetch: begin
                    pc    <= pc + 1'b1;
                    state <= vm16_pkg::st_read_d;
                end
                vm16_pkg::st_read_d: state <= vm16_pkg::st_read_a;
                vm16_pkg::st_read_a: begin
                    if (ctrl.halt) begin
                        halted <= 1'b1;
                        state  <= vm16_pkg::st_idle;
                    end else if (ctrl.has_mem) begin
                        state <= vm16_pkg::st_mem;
                    end else begin
                        state <= vm16_pkg::st_fetch;
                    end
                end
                vm16_pkg::st_mem:    state <= vm16_pkg::st_wb;
                vm16_pkg::st_wb:     state <= vm16_pkg::st_fetch;
                default:             state <= vm16_pkg::st_idle;
            endcase
        end
    end

    // instruction, operand a and scratch address
    always_ff @(posedge clk) begin
        if (state == vm16_pkg::st_fetch) begin
            instr <= vm16_pkg::instr_t'(imem_rdata);
        end
        if (state == vm16_pkg::st_read_d) begin
            alu_a <= rdata;
        end
        if (state == vm16_pkg::st_read_a) begin
            mem_addr <= alu_c[vm16_pkg::scratch_addr_w-1:0];
        end
    end

    // memory read data lags the pc by one cycle
    assign imem_addr = pc;

    assign rsel   = (state == vm16_pkg::st_read_d) ? ctrl.rd : ctrl.ra;
    assign alu_op = ctrl.alu_op;
    assign alu_b  = ctrl.has_imm8 ? {{(vm16_pkg::data_w-8){1'b0}}, ctrl.imm8} : rdata;

    // sw stores the value of rd, held in operand a
    assign smem_addr  = mem_addr;
    assign smem_wdata = alu_a;
    assign smem_we    = (state == vm16_pkg::st_mem) && ctrl.has_mem_we;

    always_comb begin
        wb.index = ctrl.rd;
        wb.valid = 1'b0;
        wb.data  = alu_c;
        case (state)
            vm16_pkg::st_read_a: wb.valid = ctrl.has_we && !ctrl.has_mem;
            vm16_pkg::st_wb: begin
                wb.valid = ctrl.has_we;
                wb.data  = smem_rdata;
            end
            default: wb.valid = 1'b0;
        endcase
    end

endmodule

// ==== rtl/vm16_core.sv ====
// vm16 processor core
`timescale 1ns/1ns

module vm16_core (
    input  logic            clk,
    input  logic            reset,
    input  vm16_pkg::prog_t prog,
    input  logic            run,
    output logic            halted,
    output vm16_pkg::wb_t   wb
);

    logic [vm16_pkg::instr_addr_w-1:0]   imem_addr;
    logic [vm16_pkg::instr_addr_w-1:0]   instr_mem_addr;
    logic [vm16_pkg::data_w-1:0]         imem_rdata;
    vm16_pkg::instr_t                    instr;
    vm16_pkg::ctrl_t                     ctrl;
    logic [vm16_pkg::reg_sel_w-1:0]      rsel;
    logic [vm16_pkg::data_w-1:0]         rdata;
    vm16_pkg::alu_op_e                   alu_op;
    logic [vm16_pkg::data_w-1:0]         alu_a;
    logic [vm16_pkg::data_w-1:0]         alu_b;
    logic [vm16_pkg::data_w-1:0]         alu_c;
    logic [vm16_pkg::scratch_addr_w-1:0] smem_addr;
    logic [vm16_pkg::data_w-1:0]         smem_wdata;
    logic                                smem_we;
    logic [vm16_pkg::data_w-1:0]         smem_rdata;

    // host load port takes the instruction memory while it writes
    assign instr_mem_addr = prog.we ? prog.addr : imem_addr;

    vm16_bram instr_mem (
        .clk(clk), .addr(instr_mem_addr), .wdata(prog.data), .we(prog.we),
        .rdata(imem_rdata)
    );

    vm16_bram scratch_mem (
        .clk(clk), .addr(smem_addr), .wdata(smem_wdata), .we(smem_we),
        .rdata(smem_rdata)
    );

    vm16_decoder decoder_i (.instr(instr), .ctrl(ctrl));

    vm16_alu alu_i (.op(alu_op), .a(alu_a), .b(alu_b), .c(alu_c));

    vm16_regfile regfile_i (
        .clk(clk), .reset(reset), .rsel(rsel), .rdata(rdata), .wb(wb)
    );

    vm16_control control_i (
        .clk(clk), .reset(reset), .run(run),
        .imem_addr(imem_addr), .imem_rdata(imem_rdata),
        .ctrl(ctrl), .instr(instr),
        .rsel(rsel), .rdata(rdata),
        .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .alu_c(alu_c),
        .smem_addr(smem_addr), .smem_wdata(smem_wdata), .smem_we(smem_we),
        .smem_rdata(smem_rdata),
        .wb(wb), .halted(halted)
    );

endmodule

// ==== rtl/vm16_decoder.sv ====
// vm16 instruction decoder
`timescale 1ns/1ns

module vm16_decoder (
    input  vm16_pkg::instr_t instr,
    output vm16_pkg::ctrl_t  ctrl
);

    always_comb begin
        ctrl      = '0;
        ctrl.rd   = instr.rd;
        ctrl.ra   = instr.ra;
        ctrl.imm8 = {instr.ra, instr.sub};
        ctrl.halt = (instr.opcode == vm16_pkg::op_halt);

        case (instr.opcode)
            vm16_pkg::op_nop,
            vm16_pkg::op_halt:    ctrl.alu_op = vm16_pkg::alu_nop;
            // loads and stores pass ra through as the address
            vm16_pkg::op_lw,
            vm16_pkg::op_sw,
            vm16_pkg::op_mov,
            vm16_pkg::op_movi:    ctrl.alu_op = vm16_pkg::alu_pass_b;
            vm16_pkg::op_bit: begin
                case (instr.sub)
                    vm16_pkg::sub_or:    ctrl.alu_op = vm16_pkg::alu_or;
                    vm16_pkg::sub_xor:   ctrl.alu_op = vm16_pkg::alu_xor;
                    vm16_pkg::sub_and:   ctrl.alu_op = vm16_pkg::alu_and;
                    vm16_pkg::sub_not:   ctrl.alu_op = vm16_pkg::alu_not;
                    vm16_pkg::sub_lshft: ctrl.alu_op = vm16_pkg::alu_lshft;
                    vm16_pkg::sub_rshft: ctrl.alu_op = vm16_pkg::alu_rshft;
                    default:             ctrl.alu_op = vm16_pkg::alu_bad;
                endcase
            end
            vm16_pkg::op_arith_u: begin
                case (instr.sub)
                    vm16_pkg::sub_add: ctrl.alu_op = vm16_pkg::alu_uadd;
                    vm16_pkg::sub_sub: ctrl.alu_op = vm16_pkg::alu_usub;
                    default:           ctrl.alu_op = vm16_pkg::alu_bad;
                endcase
            end
            vm16_pkg::op_arith_s: begin
                case (instr.sub)
                    vm16_pkg::sub_add: ctrl.alu_op = vm16_pkg::alu_sadd;
                    vm16_pkg::sub_sub: ctrl.alu_op = vm16_pkg::alu_ssub;
                    default:           ctrl.alu_op = vm16_pkg::alu_bad;
                endcase
            end
            default:              ctrl.alu_op = vm16_pkg::alu_bad;
        endcase

        ctrl.has_imm8   = (instr.opcode == vm16_pkg::op_movi);
        ctrl.has_mem    = (instr.opcode == vm16_pkg::op_lw) ||
                          (instr.opcode == vm16_pkg::op_sw);
        ctrl.has_mem_we = (instr.opcode == vm16_pkg::op_sw);

        // a bad subcode never reaches the register file
        case (instr.opcode)
            vm16_pkg::op_lw,
            vm16_pkg::op_mov,
            vm16_pkg::op_movi,
            vm16_pkg::op_bit,
            vm16_pkg::op_arith_u,
            vm16_pkg::op_arith_s: ctrl.has_we = (ctrl.alu_op != vm16_pkg::alu_bad);
            default:              ctrl.has_we = 1'b0;
        endcase
    end

endmodule

// ==== rtl/vm16_pkg.sv ====
// vm16 shared definitions
// ISA widths, encodings and bundles

package vm16_pkg;

    localparam int data_w         = 16;
    localparam int reg_sel_w      = 3;
    localparam int instr_depth    = 64;
    localparam int instr_addr_w   = $clog2(instr_depth);
    localparam int scratch_depth  = 64;
    localparam int scratch_addr_w = $clog2(scratch_depth);

    // subcodes in bits 4..0
    localparam logic [4:0] sub_or    = 5'd0;
    localparam logic [4:0] sub_xor   = 5'd1;
    localparam logic [4:0] sub_and   = 5'd2;
    localparam logic [4:0] sub_not   = 5'd3;
    localparam logic [4:0] sub_lshft = 5'd4;
    localparam logic [4:0] sub_rshft = 5'd5;
    localparam logic [4:0] sub_add   = 5'd0;
    localparam logic [4:0] sub_sub   = 5'd1;

    typedef enum logic [4:0] {
        op_nop     = 5'd0,
        op_lw      = 5'd1,
        op_sw      = 5'd2,
        op_bit     = 5'd3,
        op_mov     = 5'd4,
        op_movi    = 5'd5,
        op_arith_u = 5'd6,
        op_arith_s = 5'd7,
        op_halt    = 5'd31
    } opcode_e;

    typedef enum logic [4:0] {
        alu_nop, alu_pass_b, alu_or, alu_xor, alu_and, alu_not, alu_lshft,
        alu_rshft, alu_uadd, alu_usub, alu_sadd, alu_ssub, alu_bad
    } alu_op_e;

    typedef enum logic [2:0] {
        st_idle, st_fetch, st_read_d, st_read_a, st_mem, st_wb
    } state_e;

    // imm8 is the concatenation of ra and sub
    typedef struct packed {
        opcode_e                opcode;
        logic [reg_sel_w-1:0]   rd;
        logic [reg_sel_w-1:0]   ra;
        logic [4:0]             sub;
    } instr_t;

    typedef struct packed {
        alu_op_e              alu_op;
        logic [reg_sel_w-1:0] rd;
        logic [reg_sel_w-1:0] ra;
        logic [7:0]           imm8;
        logic                 has_imm8;
        logic                 has_we;
        logic                 has_mem;
        logic                 has_mem_we;
        logic                 halt;
    } ctrl_t;

    typedef struct packed {
        logic                    we;
        logic [instr_addr_w-1:0] addr;
        logic [data_w-1:0]       data;
    } prog_t;

    typedef struct packed {
        logic                 valid;
        logic [reg_sel_w-1:0] index;
        logic [data_w-1:0]    data;
    } wb_t;

endpackage

// ==== rtl/vm16_regfile.sv ====
// vm16 register file
`timescale 1ns/1ns

module vm16_regfile (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [vm16_pkg::reg_sel_w-1:0]  rsel,
    output logic [vm16_pkg::data_w-1:0]     rdata,
    input  vm16_pkg::wb_t                   wb
);

    logic [vm16_pkg::data_w-1:0] regs [2**vm16_pkg::reg_sel_w];

    // register i comes out of reset holding i
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**vm16_pkg::reg_sel_w; i++) begin
                regs[i] <= vm16_pkg::data_w'(i);
            end
        end else if (wb.valid) begin
            regs[wb.index] <= wb.data;
        end
    end

    assign rdata = regs[rsel];

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f project.f --top-module vm16_tb -o vm16_sim &&
./obj_dir/vm16_sim | tee /dev/stderr | grep -qF "All tests passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tb/vm16_tb.sv ====
// vm16 core testbench
// random programs checked against an ISA model
`timescale 1ns/1ns

module vm16_tb;

    logic            clk;
    logic            reset;
    logic            run;
    vm16_pkg::prog_t prog;
    logic            halted;
    vm16_pkg::wb_t   wb;

    logic [15:0]     lfsr = 16'd43;
    logic [15:0]     program_words [64];
    int              n_instr;
    logic [15:0]     model_regs [8];
    logic [15:0]     model_mem [64];
    vm16_pkg::wb_t   exp_q [$];
    vm16_pkg::wb_t   exp_head;
    int              observed = 0;
    int              expected_events;

    vm16_core dut_i (
        .clk(clk), .reset(reset), .prog(prog), .run(run), .halted(halted), .wb(wb)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // taps 16, 14, 13, 11
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[14:0], next_bit()};
        end
        return v;
    endfunction

    function automatic logic [15:0] encode(input logic [4:0] op, input logic [2:0] rd,
                                           input logic [2:0] ra, input logic [4:0] sub);
        return {op, rd, ra, sub};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("Fail %s: got 0x%h expected 0x%h", name, got, expected));
        end
    endtask

    // reference model of one instruction, queues the write-back it must cause
    task automatic model_exec(input logic [15:0] word);
        logic [2:0]    rd;
        logic [2:0]    ra;
        logic [4:0]    sub;
        logic [15:0]   a;
        logic [15:0]   b;
        logic [15:0]   c;
        logic          we;
        vm16_pkg::wb_t ev;
        rd  = word[10:8];
        ra  = word[7:5];
        sub = word[4:0];
        a   = model_regs[rd];
        b   = model_regs[ra];
        c   = 16'h0000;
        we  = 1'b1;
        case (word[15:11])
            vm16_pkg::op_mov:  c = b;
            vm16_pkg::op_movi: c = {8'h00, word[7:0]};
            vm16_pkg::op_bit: begin
                case (sub)
                    vm16_pkg::sub_or:    c = a | b;
                    vm16_pkg::sub_xor:   c = a ^ b;
                    vm16_pkg::sub_and:   c = a & b;
                    vm16_pkg::sub_not:   c = ~b;
                    vm16_pkg::sub_lshft: c = (b > 16'd15) ? 16'h0000 : a << b[3:0];
                    vm16_pkg::sub_rshft: c = (b > 16'd15) ? 16'h0000 : a >> b[3:0];
                    default:             we = 1'b0;
                endcase
            end
            // signed and unsigned wrap to the same bits
            vm16_pkg::op_arith_u, vm16_pkg::op_arith_s: begin
                case (sub)
                    vm16_pkg::sub_add: c = a + b;
                    vm16_pkg::sub_sub: c = a - b;
                    default:           we = 1'b0;
                endcase
            end
            vm16_pkg::op_sw: begin
                model_mem[b[5:0]] = a;
                we = 1'b0;
            end
            vm16_pkg::op_lw:   c = model_mem[b[5:0]];
            default:           we = 1'b0;
        endcase
        if (we) begin
            model_regs[rd] = c;
            ev.valid = 1'b1;
            ev.index = rd;
            ev.data  = c;
            exp_q.push_back(ev);
        end
    endtask

    task automatic add_instr(input logic [15:0] word);
        program_words[6'(n_instr)] = word;
        model_exec(word);
        n_instr++;
    endtask

    task automatic build_program();
        logic [2:0] kind;
        logic [2:0] rd;
        logic [2:0] ra;
        logic [4:0] sub;
        logic [7:0] imm;
        n_instr = 0;
        for (int i = 0; i < 8; i++) begin
            model_regs[3'(i)] = 16'(i);
        end
        for (int i = 0; i < 64; i++) begin
            model_mem[6'(i)] = 16'h0000;
        end
        // each register read back before anything writes it
        for (int i = 0; i < 8; i++) begin
            add_instr(encode(vm16_pkg::op_mov, 3'(i), 3'(i), 5'd0));
        end
        // scratch memory is still empty here
        add_instr(encode(vm16_pkg::op_lw, 3'(rand_bits(3)), 3'(rand_bits(3)), 5'd0));
        while (n_instr < 62) begin
            kind = 3'(rand_bits(3));
            rd   = 3'(rand_bits(3));
            ra   = 3'(rand_bits(3));
            case (kind)
                3'd0, 3'd1: begin
                    sub = 5'(rand_bits(3));
                    if (sub > 5'd5) begin
                        sub = sub - 5'd2;
                    end
                    add_instr(encode(vm16_pkg::op_bit, rd, ra, sub));
                end
                3'd2: add_instr(encode(vm16_pkg::op_arith_u, rd, ra, 5'(rand_bits(1))));
                3'd3: add_instr(encode(vm16_pkg::op_arith_s, rd, ra, 5'(rand_bits(1))));
                3'd4: begin
                    imm = 8'(rand_bits(8));
                    add_instr(encode(vm16_pkg::op_movi, rd, imm[7:5], imm[4:0]));
                end
                3'd5: begin
                    add_instr(encode(vm16_pkg::op_sw, rd, ra, 5'd0));
                    if (n_instr < 62) begin
                        add_instr(encode(vm16_pkg::op_lw, 3'(rand_bits(3)), ra, 5'd0));
                    end
                end
                3'd6: begin
                    if (rand_bits(1) == 16'd1) begin
                        add_instr(encode(5'd8 + 5'(rand_bits(4)), rd, ra, 5'd0));
                    end else if (rand_bits(1) == 16'd1) begin
                        add_instr(encode(vm16_pkg::op_bit, rd, ra, 5'd6 + 5'(rand_bits(4))));
                    end else begin
                        add_instr(encode(vm16_pkg::op_arith_u, rd, ra,
                                         5'd2 + 5'(rand_bits(4))));
                    end
                end
                default: begin
                    if (rand_bits(1) == 16'd1) begin
                        add_instr(encode(vm16_pkg::op_mov, rd, ra, 5'd0));
                    end else begin
                        add_instr(encode(vm16_pkg::op_nop, rd, ra, 5'd0));
                    end
                end
            endcase
        end
        add_instr(encode(vm16_pkg::op_halt, 3'd0, 3'd0, 5'd0));
    endtask

    // write-back monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (wb.valid) begin
            if (exp_q.size() == 0) begin
                abort_run("write-back pulse seen when none was expected");
            end else begin
                exp_head = exp_q.pop_front();
                check_value("wb.index", 32'(wb.index), 32'(exp_head.index));
                check_value("wb.data", 32'(wb.data), 32'(exp_head.data));
                observed++;
            end
        end
    end

    initial begin
        int cycles;
        int events_at_halt;
        reset = 1'b1;
        run   = 1'b0;
        prog  = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        for (cycles = 0; cycles < 20; cycles++) begin
            @(negedge clk);
            check_value("wb.valid", 32'(wb.valid), 32'd0);
            check_value("halted", 32'(halted), 32'd0);
        end
        build_program();
        expected_events = exp_q.size();
        for (int a = 0; a < n_instr; a++) begin
            @(posedge clk);
            #1;
            prog.we   = 1'b1;
            prog.addr = 6'(a);
            prog.data = program_words[6'(a)];
        end
        @(posedge clk);
        #1;
        prog = '0;
        @(posedge clk);
        #1;
        run = 1'b1;
        cycles = 0;
        while (!halted && cycles < 2000) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!halted) begin
            abort_run("timed out waiting for halted after the program started");
        end else begin
            events_at_halt = observed;
            repeat (50) @(posedge clk);
            check_value("events after halt", 32'(observed), 32'(events_at_halt));
            check_value("event count", 32'(observed), 32'(expected_events));
            $display("All tests passed");
            $finish;
        end
    end

endmodule
